// ==== alu/alu.sv ====
// Integer ALU
`timescale 1ns/1ps

module alu (
  input  logic [mipsPkg::dataW-1:0] operandA,
  input  logic [mipsPkg::dataW-1:0] operandB,
  input  mipsPkg::aluOpE            op,
  output logic [mipsPkg::dataW-1:0] result,
  output logic                      zero
);
  import mipsPkg::*;

  always_comb begin
    case (op)
      aluAnd: result = operandA & operandB;
      aluOr:  result = operandA | operandB;
      aluAdd: result = operandA + operandB;
      aluSub: result = operandA - operandB;
      // Signed compare.
      aluSlt: begin
        if ($signed(operandA) < $signed(operandB)) begin
          result = dataW'(1);
        end else begin
          result = '0;
        end
      end
      default: result = '0;
    endcase
  end

  // Used by beq
  assign zero = (result == '0);

endmodule

// ==== common/mipsPkg.sv ====
// MIPS pipeline definitions
package mipsPkg;

  // Machine word and register number widths.
  localparam int dataW    = 32;
  localparam int regAddrW = 5;

  // Fetch address after reset.
  localparam logic [dataW-1:0] resetPc = '0;

  // All-zero word decodes to a nop.
  localparam logic [dataW-1:0] nopInstr = '0;

  // Major opcodes, instr[31:26].
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeE;

  // R-type function codes, instr[5:0].
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functE;

  // ALU operations.
  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpE;

  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memWrite;
    logic  branch;
    aluOpE aluOp;
    logic  aluSrc;
    logic  regDst;
  } ctrlT;

  typedef struct packed {
    logic [dataW-1:0] instr;
    logic [dataW-1:0] pcPlus4;
  } ifIdT;

  typedef struct packed {
    ctrlT                ctrl;
    logic [dataW-1:0]    rsVal;
    logic [dataW-1:0]    rtVal;
    logic [regAddrW-1:0] rtNum;
    logic [regAddrW-1:0] rdNum;
    logic [dataW-1:0]    signImm;
    logic [dataW-1:0]    pcPlus4;
  } idExT;

  typedef struct packed {
    logic                regWrite;
    logic                memToReg;
    logic                memWrite;
    logic                branch;
    logic                zero;
    logic [dataW-1:0]    aluOut;
    logic [dataW-1:0]    writeData;
    logic [regAddrW-1:0] writeReg;
    logic [dataW-1:0]    pcBranch;
  } exMemT;

  // Write-back path into the register file.
  typedef struct packed {
    logic                regWrite;
    logic [regAddrW-1:0] writeReg;
    logic [dataW-1:0]    result;
  } wbT;

endpackage

// ==== cpu.f ====
+incdir+test
common/mipsPkg.sv
regfile/regfile.sv
alu/alu.sv
verilog/controlUnit.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpu.sv
test/cpuTb.sv

// ==== regfile/regfile.sv ====
// Register file
`timescale 1ns/1ps

module regfile (
  input  logic                         clk,
  input  logic [mipsPkg::regAddrW-1:0] readReg1,
  input  logic [mipsPkg::regAddrW-1:0] readReg2,
  output logic [mipsPkg::dataW-1:0]    readData1,
  output logic [mipsPkg::dataW-1:0]    readData2,
  input  logic                         writeEnable,
  input  logic [mipsPkg::regAddrW-1:0] writeReg,
  input  logic [mipsPkg::dataW-1:0]    writeData
);
  import mipsPkg::*;

  logic [dataW-1:0] regs [2**regAddrW];
  logic             writing;

  // Register 0 is never written.
  assign writing = writeEnable && (writeReg != '0);

  always_ff @(posedge clk) begin
    if (writing) begin
      regs[writeReg] <= writeData;
    end
  end

  // Same-cycle write goes through to the readers.
  assign readData1 = (readReg1 == '0) ? '0 :
                     (writing && writeReg == readReg1) ? writeData : regs[readReg1];
  assign readData2 = (readReg2 == '0) ? '0 :
                     (writing && writeReg == readReg2) ? writeData : regs[readReg2];

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert --top-module cpuTb -f cpu.f -o cpuSim \
  && ./obj_dir/cpuSim | tee /dev/stderr | grep "TEST OK" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== test/cpuProgram.svh ====
// Test program and expected stores
`ifndef CPU_PROGRAM_SVH
`define CPU_PROGRAM_SVH

localparam int progLen    = 32;
localparam int storeCount = 15;

// Word 31 jumps to itself.
localparam logic [31:0] haltAddr = 32'h0000_007C;

// Word read by the lw at byte address 0x80.
localparam int          preloadIdx  = 32;
localparam logic [31:0] preloadWord = 32'h1234_5678;

typedef struct packed {
  logic [31:0] addr;
  logic [31:0] data;
} storeT;

// Every consumer sits at least three words after its producer.
localparam logic [31:0] progWords [progLen] = '{
  // addi r1 5, addi r2 -3, addi r3 12, addi r10 0x40, lw r11 0x80(r0).
  32'h2001_0005, 32'h2002_FFFD, 32'h2003_000C, 32'h200A_0040,
  32'h8C0B_0080,
  // add r4, sub r5, and r6, or r7, slt r8 (r2<r1), slt r9 (r1<r2).
  32'h0022_2020, 32'h0023_2822, 32'h0023_3024, 32'h0023_3825,
  32'h0041_402A, 32'h0022_482A,
  // sw r4..r9 and r11 to 0x40..0x58.
  32'hAD44_0000, 32'hAD45_0004, 32'hAD46_0008, 32'hAD47_000C,
  32'hAD48_0010, 32'hAD49_0014, 32'hAD4B_0018,
  // beq r1 r1 taken to word 23, three shadow stores, then a skipped marker.
  32'h1021_0004,
  32'hAD41_001C, 32'hAD43_0020, 32'hAD42_0024,
  32'hAD43_007C,
  // beq r1 r2 not taken, three shadow stores, then a marker that goes through.
  32'h1022_0004,
  32'hAD44_002C, 32'hAD46_0030, 32'hAD47_0034,
  32'hAD48_0038,
  // j to word 30 over a marker, the store at the target, then the halt loop.
  32'h0800_001E,
  32'hAD49_0078,
  32'hAD43_003C,
  32'h0800_001F
};

// Address in the upper half, data in the lower half.
localparam storeT expStores [storeCount] = '{
  64'h0000_0040_0000_0002,
  64'h0000_0044_FFFF_FFF9,
  64'h0000_0048_0000_0004,
  64'h0000_004C_0000_000D,
  64'h0000_0050_0000_0001,
  64'h0000_0054_0000_0000,
  64'h0000_0058_1234_5678,
  64'h0000_005C_0000_0005,
  64'h0000_0060_0000_000C,
  64'h0000_0064_FFFF_FFFD,
  64'h0000_006C_0000_0002,
  64'h0000_0070_0000_0004,
  64'h0000_0074_0000_000D,
  64'h0000_0078_0000_0001,
  64'h0000_007C_0000_000C
};

`endif

// ==== test/cpuTb.sv ====
// Pipelined CPU testbench
`timescale 1ns/1ps

module cpuTb;
  import mipsPkg::*;

  `include "cpuProgram.svh"

  localparam int resetCycles = 8;
  // Reset, the program, and margin for the pipeline to drain.
  localparam int watchdogCycles = resetCycles + progLen + 20;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr = nopInstr;
  logic [31:0] dataAddr;
  logic [31:0] dataWrite;
  logic        memWriteEnable;
  logic [31:0] dataRead = '0;

  logic [31:0] dmem [64];
  int          storeIdx = 0;
  int          resetErrors = 0;
  int          fetchErrors = 0;
  int          storeErrors = 0;

  // Fetch history for the next-address check.
  logic        fetchValid = 1'b0;
  logic [31:0] prevAddr;
  logic [31:0] prevInstr;
  logic [3:0]  beqAge = '0;
  logic [31:0] prevPlus4;
  logic [31:0] expectedNext;

  cpu uut (
    .clk            (clk),
    .rst            (rst),
    .instrAddr      (instrAddr),
    .instr          (instr),
    .dataAddr       (dataAddr),
    .dataWrite      (dataWrite),
    .memWriteEnable (memWriteEnable),
    .dataRead       (dataRead)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] fetchWord(input logic [31:0] addr);
    if (addr < 32'(progLen * 4)) begin
      return progWords[addr[6:2]];
    end
    return nopInstr;
  endfunction

  // Memories answer on the falling edge, stable by the next rising edge.
  always @(negedge clk) begin
    instr    <= fetchWord(instrAddr);
    dataRead <= dmem[dataAddr[7:2]];
  end

  always @(posedge clk) begin
    if (memWriteEnable) begin
      dmem[dataAddr[7:2]] = dataWrite;
      storeIdx <= storeIdx + 1;
    end
    fetchValid <= !rst;
    prevAddr   <= instrAddr;
    prevInstr  <= instr;
    beqAge     <= {beqAge[2:0], !rst && instr[31:26] == opBeq};
  end

  // The program sits in low memory, where a j target is its word index times four.
  assign prevPlus4    = prevAddr + 32'd4;
  assign expectedNext = (prevInstr[31:26] == opJ) ?
                        32'(prevInstr[25:0]) << 2 : prevPlus4;

  resetAddrCheck: assert property (@(negedge clk) rst |-> instrAddr == resetPc)
    else begin
      resetErrors++;
      $display("error reset pc: expected %h, got %h", resetPc, instrAddr);
    end

  resetStoreCheck: assert property (@(negedge clk) rst |-> !memWriteEnable)
    else begin
      resetErrors++;
      $display("a store was issued during reset");
    end

  // Four cycles after a beq the address depends on its operands.
  fetchAddrCheck: assert property (@(negedge clk)
      fetchValid && !beqAge[3] |-> instrAddr == expectedNext)
    else begin
      fetchErrors++;
      $display("error fetch pc: expected %h, got %h", expectedNext, instrAddr);
    end

  storeCountCheck: assert property (@(negedge clk) memWriteEnable |-> storeIdx < storeCount)
    else begin
      storeErrors++;
      $display("an unexpected extra store was issued to address %h", dataAddr);
    end

  storeAddrCheck: assert property (@(negedge clk)
      memWriteEnable && storeIdx < storeCount |-> dataAddr == expStores[storeIdx].addr)
    else begin
      storeErrors++;
      $display("error store %0d address: expected %h, got %h",
               storeIdx, expStores[storeIdx].addr, dataAddr);
    end

  storeDataCheck: assert property (@(negedge clk)
      memWriteEnable && storeIdx < storeCount |-> dataWrite == expStores[storeIdx].data)
    else begin
      storeErrors++;
      $display("error store %0d data: expected %h, got %h",
               storeIdx, expStores[storeIdx].data, dataWrite);
    end

  initial begin
    rst <= 1'b1;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = 32'hDA7A_0000 + 32'(i);
    end
    dmem[preloadIdx] = preloadWord;
    repeat (resetCycles) @(negedge clk);
    rst <= 1'b0;
    wait (instrAddr == haltAddr);
    // Let the last store leave the memory stage.
    repeat (4) @(posedge clk);
    @(negedge clk);
    storeTotalCheck: assert (storeIdx == storeCount)
      else begin
        storeErrors++;
        $display("error store count: expected %0d, got %0d", storeCount, storeIdx);
      end
    $display("errors: reset %0d, fetch %0d, store %0d", resetErrors, fetchErrors, storeErrors);
    if (resetErrors + fetchErrors + storeErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * 10);
    $display("timeout: the halt loop was not reached within %0d cycles", watchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog/controlUnit.sv ====
// Main control decoder
`timescale 1ns/1ps

module controlUnit (
  input  mipsPkg::opcodeE opcode,
  input  mipsPkg::functE  funct,
  output mipsPkg::ctrlT   ctrl
);
  import mipsPkg::*;

  always_comb begin
    ctrl = '0;
    case (opcode)
      opRType: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          // Unsupported funct decodes as a nop.
          default: ctrl = '0;
        endcase
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      // Jumps are taken in fetch.
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    noStoreWrite: assert (!(ctrl.memWrite && ctrl.regWrite));
  end

endmodule

// ==== verilog/cpu.sv ====
// Pipelined MIPS core
`timescale 1ns/1ps

module cpu (
  input  logic                       clk,
  input  logic                       rst,
  output logic [mipsPkg::dataW-1:0]  instrAddr,
  input  logic [mipsPkg::dataW-1:0]  instr,
  output logic [mipsPkg::dataW-1:0]  dataAddr,
  output logic [mipsPkg::dataW-1:0]  dataWrite,
  output logic                       memWriteEnable,
  input  logic [mipsPkg::dataW-1:0]  dataRead
);
  import mipsPkg::*;

  // Pipeline registers between stages.
  ifIdT  ifId;
  idExT  idEx;
  exMemT exMem;
  wbT    wb;

  // Branch redirect from the memory stage.
  logic             pcSource;
  logic [dataW-1:0] pcBranch;

  fetchStage fetch (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .pcSource  (pcSource),
    .pcBranch  (pcBranch),
    .instrAddr (instrAddr),
    .ifId      (ifId)
  );

  decodeStage decode (
    .clk  (clk),
    .rst  (rst),
    .ifId (ifId),
    .wb   (wb),
    .idEx (idEx)
  );

  executeStage execute (
    .clk   (clk),
    .rst   (rst),
    .idEx  (idEx),
    .exMem (exMem)
  );

  memWbStage memWb (
    .clk      (clk),
    .rst      (rst),
    .exMem    (exMem),
    .dataRead (dataRead),
    .pcSource (pcSource),
    .pcBranch (pcBranch),
    .wb       (wb)
  );

  // Data memory is driven straight from EX/MEM.
  assign dataAddr       = exMem.aluOut;
  assign dataWrite      = exMem.writeData;
  assign memWriteEnable = exMem.memWrite;

endmodule

// ==== verilog/decodeStage.sv ====
// Instruction decode stage
`timescale 1ns/1ps

module decodeStage (
  input  logic          clk,
  input  logic          rst,
  input  mipsPkg::ifIdT ifId,
  input  mipsPkg::wbT   wb,
  output mipsPkg::idExT idEx
);
  import mipsPkg::*;

  ctrlT                ctrl;
  logic [dataW-1:0]    rsVal;
  logic [dataW-1:0]    rtVal;
  logic [regAddrW-1:0] rsNum;
  logic [regAddrW-1:0] rtNum;
  logic [regAddrW-1:0] rdNum;
  logic [dataW-1:0]    signImm;

  // Instruction fields.
  assign rsNum = ifId.instr[25:21];
  assign rtNum = ifId.instr[20:16];
  assign rdNum = ifId.instr[15:11];

  assign signImm = {{(dataW - 16){ifId.instr[15]}}, ifId.instr[15:0]};

  controlUnit control (
    .opcode (opcodeE'(ifId.instr[31:26])),
    .funct  (functE'(ifId.instr[5:0])),
    .ctrl   (ctrl)
  );

  // Written from the write-back stage.
  regfile regs (
    .clk         (clk),
    .readReg1    (rsNum),
    .readReg2    (rtNum),
    .readData1   (rsVal),
    .readData2   (rtVal),
    .writeEnable (wb.regWrite),
    .writeReg    (wb.writeReg),
    .writeData   (wb.result)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.ctrl <= '0;
    end else begin
      idEx.ctrl <= ctrl;
    end
    idEx.rsVal   <= rsVal;
    idEx.rtVal   <= rtVal;
    idEx.rtNum   <= rtNum;
    idEx.rdNum   <= rdNum;
    idEx.signImm <= signImm;
    idEx.pcPlus4 <= ifId.pcPlus4;
  end

endmodule

// ==== verilog/executeStage.sv ====
// Execute stage
`timescale 1ns/1ps

module executeStage (
  input  logic            clk,
  input  logic            rst,
  input  mipsPkg::idExT   idEx,
  output mipsPkg::exMemT  exMem
);
  import mipsPkg::*;

  logic [dataW-1:0]    operandB;
  logic [dataW-1:0]    aluOut;
  logic                zero;
  logic [regAddrW-1:0] writeReg;
  logic [dataW-1:0]    pcBranch;

  // Immediate or rt as the second operand.
  assign operandB = idEx.ctrl.aluSrc ? idEx.signImm : idEx.rtVal;

  // R-type writes rd, the rest write rt.
  assign writeReg = idEx.ctrl.regDst ? idEx.rdNum : idEx.rtNum;

  assign pcBranch = idEx.pcPlus4 + (idEx.signImm << 2);

  alu arith (
    .operandA (idEx.rsVal),
    .operandB (operandB),
    .op       (idEx.ctrl.aluOp),
    .result   (aluOut),
    .zero     (zero)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.regWrite <= 1'b0;
      exMem.memToReg <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.branch   <= 1'b0;
    end else begin
      exMem.regWrite <= idEx.ctrl.regWrite;
      exMem.memToReg <= idEx.ctrl.memToReg;
      exMem.memWrite <= idEx.ctrl.memWrite;
      exMem.branch   <= idEx.ctrl.branch;
    end
    exMem.zero      <= zero;
    exMem.aluOut    <= aluOut;
    exMem.writeData <= idEx.rtVal;
    exMem.writeReg  <= writeReg;
    exMem.pcBranch  <= pcBranch;
  end

endmodule

// ==== verilog/fetchStage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps

module fetchStage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [mipsPkg::dataW-1:0] instr,
  input  logic                      pcSource,
  input  logic [mipsPkg::dataW-1:0] pcBranch,
  output logic [mipsPkg::dataW-1:0] instrAddr,
  output mipsPkg::ifIdT             ifId
);
  import mipsPkg::*;

  logic [dataW-1:0] pcPlus4;
  logic [dataW-1:0] nextPc;

  assign pcPlus4 = instrAddr + dataW'(4);

  // Branch select first, then a jump in fetch overrides it.
  always_comb begin
    nextPc = pcSource ? pcBranch : pcPlus4;
    if (opcodeE'(instr[31:26]) == opJ) begin
      nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      instrAddr  <= resetPc;
      ifId.instr <= nopInstr;
    end else begin
      instrAddr  <= nextPc;
      ifId.instr <= instr;
    end
    ifId.pcPlus4 <= pcPlus4;
  end

  // Branch and jump targets must keep the PC on word boundaries.
  pcAligned: assert property (@(posedge clk) disable iff (rst) instrAddr[1:0] == 2'b00);

endmodule

// ==== verilog/memWbStage.sv ====
// Memory and write-back stages
`timescale 1ns/1ps

module memWbStage (
  input  logic                      clk,
  input  logic                      rst,
  input  mipsPkg::exMemT            exMem,
  input  logic [mipsPkg::dataW-1:0] dataRead,
  output logic                      pcSource,
  output logic [mipsPkg::dataW-1:0] pcBranch,
  output mipsPkg::wbT               wb
);
  import mipsPkg::*;

  logic                regWrite;
  logic                memToReg;
  logic [dataW-1:0]    aluOut;
  logic [dataW-1:0]    readData;
  logic [regAddrW-1:0] writeReg;

  // Branch resolves in the memory stage.
  assign pcSource = exMem.branch & exMem.zero;
  assign pcBranch = exMem.pcBranch;

  always_ff @(posedge clk) begin
    if (rst) begin
      regWrite <= 1'b0;
      memToReg <= 1'b0;
    end else begin
      regWrite <= exMem.regWrite;
      memToReg <= exMem.memToReg;
    end
    aluOut   <= exMem.aluOut;
    readData <= dataRead;
    writeReg <= exMem.writeReg;
  end

  assign wb.regWrite = regWrite;
  assign wb.writeReg = writeReg;
  assign wb.result   = memToReg ? readData : aluOut;

endmodule
